// File: rtl/dpCtrlPkg.sv
package dpCtrlPkg;

    ////////////////////
    // Data word
    ////////////////////

    typedef logic [31:0] wordT;

    ////////////////////
    // Bus sources
    ////////////////////

    // Sources other than the general registers that may drive the shared bus
    // none leaves the bus to the register file or to zero
    typedef enum logic [3:0] {
        gpr    = 4'd0,
        pc     = 4'd1,
        zHigh  = 4'd2,
        zLow   = 4'd3,
        hi     = 4'd4,
        lo     = 4'd5,
        mdr    = 4'd6,
        inPort = 4'd7,
        cExt   = 4'd8,
        none   = 4'd9
    } busSrcE;

    ////////////////////
    // Control word
    ////////////////////

    // One word per clock; each strobe acts on the next rising edge only
    typedef struct packed {
        logic   pcIn;
        logic   irIn;
        logic   yIn;
        logic   zIn;
        logic   hiIn;
        logic   loIn;
        logic   marIn;
        logic   mdrIn;
        logic   outPortIn;
        logic   read;       // MDR takes memory data instead of the bus
        logic   write;      // Memory write strobe
        logic   gra;
        logic   grb;
        logic   grc;
        logic   rIn;
        logic   rOut;
        logic   baOut;      // Base address out, R0 reads as zero
        busSrcE busSrc;
    } ctrlWordT;

endpackage

// File: rtl/isaPkg.sv
package isaPkg;

    // General register index taken from the ra, rb and rc fields
    typedef logic [3:0] regIdxT;

    // ALU opcodes, other codes pass the bus value through
    typedef enum logic [4:0] {
        add   = 5'd3,
        sub   = 5'd4,
        andOp = 5'd5,
        orOp  = 5'd6,
        shr   = 5'd7,
        shl   = 5'd9,
        mul   = 5'd15,
        neg   = 5'd17,
        notOp = 5'd18
    } opcodeE;

    ////////////////////
    // Instruction formats
    ////////////////////

    // Three register form
    typedef struct packed {
        opcodeE       opcode;
        regIdxT       ra;
        regIdxT       rb;
        regIdxT       rc;
        logic [14:0]  unused;
    } rFormT;

    // Immediate form with a signed 19 bit constant
    typedef struct packed {
        opcodeE       opcode;
        regIdxT       ra;
        regIdxT       rb;
        logic [18:0]  c;
    } iFormT;

    typedef union packed {
        rFormT rForm;
        iFormT iForm;
    } instrU;

endpackage

// File: rtl/regFile.sv
`timescale 1ns/1ps

module regFile #(
    parameter int numRegs = 16
) (
    input  logic            clk,
    input  logic            rstN,
    input  logic            rIn,
    input  logic            rOut,
    input  logic            baOut,
    input  isaPkg::regIdxT  sel,
    input  dpCtrlPkg::wordT busData,
    output dpCtrlPkg::wordT regData
);

    localparam int idxW = $clog2(numRegs);

    dpCtrlPkg::wordT regs [numRegs];
    logic [idxW-1:0] idx;

    // Upper index bits are ignored in a smaller register file
    assign idx = sel[idxW-1:0];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (rIn) begin
            regs[idx] <= busData;
        end
    end

    // R0 reads as zero in base address mode
    assign regData = (baOut && idx == '0) ? '0 : regs[idx];

    ////////////////////
    // Checks
    ////////////////////

    // Normal and base address reads are exclusive
    assert property (@(posedge clk) disable iff (!rstN) !(rOut && baOut))
        else $error("rOut and baOut both set");

endmodule

// File: rtl/irDecode.sv
`timescale 1ns/1ps

module irDecode (
    input  logic            clk,
    input  logic            rstN,
    input  logic            irIn,
    input  logic            gra,
    input  logic            grb,
    input  logic            grc,
    input  dpCtrlPkg::wordT busData,
    output isaPkg::regIdxT  sel,
    output isaPkg::opcodeE  opcode,
    output dpCtrlPkg::wordT cExt
);

    isaPkg::instrU ir;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ir <= '0;
        end else if (irIn) begin
            ir <= busData;
        end
    end

    assign opcode = ir.rForm.opcode;

    // Select and encode
    always_comb begin
        if (gra) begin
            sel = ir.rForm.ra;
        end else if (grb) begin
            sel = ir.rForm.rb;
        end else if (grc) begin
            sel = ir.rForm.rc;
        end else begin
            sel = '0;
        end
    end

    // Same word read as an immediate
    assign cExt = {{13{ir.iForm.c[18]}}, ir.iForm.c};

    assert property (@(posedge clk) disable iff (!rstN) $onehot0({gra, grb, grc}))
        else $error("more than one of gra, grb, grc set");

endmodule

// File: rtl/aluUnit.sv
`timescale 1ns/1ps

module aluUnit (
    input  logic            clk,
    input  logic            rstN,
    input  logic            yIn,
    input  logic            zIn,
    input  logic            hiIn,
    input  logic            loIn,
    input  isaPkg::opcodeE  opcode,
    input  dpCtrlPkg::wordT busData,
    output dpCtrlPkg::wordT zHigh,
    output dpCtrlPkg::wordT zLow,
    output dpCtrlPkg::wordT hi,
    output dpCtrlPkg::wordT lo
);

    dpCtrlPkg::wordT    y;
    dpCtrlPkg::wordT    hiReg;
    dpCtrlPkg::wordT    loReg;
    dpCtrlPkg::wordT    aluRes;
    logic        [63:0] z;
    logic        [63:0] aluOut;
    logic signed [63:0] product;

    ////////////////////
    // Operations
    ////////////////////

    assign product = $signed(y) * $signed(busData);

    // Y is the first operand, the bus the second
    always_comb begin
        case (opcode)
            isaPkg::add:   aluRes = y + busData;
            isaPkg::sub:   aluRes = y - busData;
            isaPkg::andOp: aluRes = y & busData;
            isaPkg::orOp:  aluRes = y | busData;
            isaPkg::shl:   aluRes = y << busData[4:0];
            isaPkg::shr:   aluRes = y >> busData[4:0];
            // Unary operations act on the bus
            isaPkg::neg:   aluRes = -busData;
            isaPkg::notOp: aluRes = ~busData;
            isaPkg::mul:   aluRes = product[31:0];
            default:       aluRes = busData;
        endcase
    end

    assign aluOut = (opcode == isaPkg::mul) ? product : {{32{aluRes[31]}}, aluRes};

    ////////////////////
    // Registers
    ////////////////////

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            y     <= '0;
            z     <= '0;
            hiReg <= '0;
            loReg <= '0;
        end else begin
            if (yIn) begin
                y <= busData;
            end
            if (zIn) begin
                z <= aluOut;
            end
            if (hiIn) begin
                hiReg <= busData;
            end
            if (loIn) begin
                loReg <= busData;
            end
        end
    end

    assign zHigh = z[63:32];
    assign zLow  = z[31:0];
    assign hi    = hiReg;
    assign lo    = loReg;

endmodule

// File: rtl/memRegs.sv
`timescale 1ns/1ps

module memRegs (
    input  logic            clk,
    input  logic            rstN,
    input  logic            pcIn,
    input  logic            marIn,
    input  logic            mdrIn,
    input  logic            read,
    input  logic            outPortIn,
    input  dpCtrlPkg::wordT busData,
    input  dpCtrlPkg::wordT memDataIn,
    output dpCtrlPkg::wordT pc,
    output dpCtrlPkg::wordT mdr,
    output dpCtrlPkg::wordT memAddr,
    output dpCtrlPkg::wordT outPortData
);

    dpCtrlPkg::wordT pcReg;
    dpCtrlPkg::wordT marReg;
    dpCtrlPkg::wordT mdrReg;
    dpCtrlPkg::wordT outReg;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pcReg  <= '0;
            marReg <= '0;
            mdrReg <= '0;
            outReg <= '0;
        end else begin
            if (pcIn) begin
                pcReg <= busData;
            end
            if (marIn) begin
                marReg <= busData;
            end
            // Memory read or bus load
            if (mdrIn) begin
                mdrReg <= read ? memDataIn : busData;
            end
            if (outPortIn) begin
                outReg <= busData;
            end
        end
    end

    assign pc          = pcReg;
    assign mdr         = mdrReg;
    assign memAddr     = marReg;
    assign outPortData = outReg;

endmodule

// File: rtl/busSelect.sv
`timescale 1ns/1ps

module busSelect (
    input  dpCtrlPkg::ctrlWordT ctrl,
    input  dpCtrlPkg::wordT     regData,
    input  dpCtrlPkg::wordT     pc,
    input  dpCtrlPkg::wordT     zHigh,
    input  dpCtrlPkg::wordT     zLow,
    input  dpCtrlPkg::wordT     hi,
    input  dpCtrlPkg::wordT     lo,
    input  dpCtrlPkg::wordT     mdr,
    input  dpCtrlPkg::wordT     inPortData,
    input  dpCtrlPkg::wordT     cExt,
    output dpCtrlPkg::wordT     busData
);

    localparam int numSrc = int'(dpCtrlPkg::none);

    logic              regOut;
    logic [numSrc-1:0] srcHot;

    assign regOut = ctrl.rOut || ctrl.baOut;

    // Register strobes take priority over busSrc
    always_comb begin
        for (int i = 0; i < numSrc; i++) begin
            srcHot[i] = !regOut && (ctrl.busSrc == dpCtrlPkg::busSrcE'(i));
        end
        srcHot[dpCtrlPkg::gpr] = regOut || (ctrl.busSrc == dpCtrlPkg::gpr);
    end

    // AND-OR mux, zero when nothing drives
    assign busData = ({32{srcHot[dpCtrlPkg::gpr]}}    & regData)
                   | ({32{srcHot[dpCtrlPkg::pc]}}     & pc)
                   | ({32{srcHot[dpCtrlPkg::zHigh]}}  & zHigh)
                   | ({32{srcHot[dpCtrlPkg::zLow]}}   & zLow)
                   | ({32{srcHot[dpCtrlPkg::hi]}}     & hi)
                   | ({32{srcHot[dpCtrlPkg::lo]}}     & lo)
                   | ({32{srcHot[dpCtrlPkg::mdr]}}    & mdr)
                   | ({32{srcHot[dpCtrlPkg::inPort]}} & inPortData)
                   | ({32{srcHot[dpCtrlPkg::cExt]}}   & cExt);

    // A second driver next to a register read would be lost silently
    always_comb begin
        assert (!(regOut && ctrl.busSrc != dpCtrlPkg::none))
            else $error("register read combined with bus source %0d", ctrl.busSrc);
    end

endmodule

// File: rtl/dataPath.sv
`timescale 1ns/1ps

module dataPath #(
    parameter int numRegs = 16
) (
    input  logic                clk,
    input  logic                rstN,
    input  dpCtrlPkg::ctrlWordT ctrl,
    input  dpCtrlPkg::wordT     memDataIn,
    input  dpCtrlPkg::wordT     inPortData,
    output dpCtrlPkg::wordT     busData,
    output dpCtrlPkg::wordT     memAddr,
    output dpCtrlPkg::wordT     memWriteData,
    output logic                memWrite,
    output dpCtrlPkg::wordT     outPortData
);

    isaPkg::regIdxT  sel;
    isaPkg::opcodeE  opcode;
    dpCtrlPkg::wordT regData;
    dpCtrlPkg::wordT cExt;
    dpCtrlPkg::wordT zHigh;
    dpCtrlPkg::wordT zLow;
    dpCtrlPkg::wordT hi;
    dpCtrlPkg::wordT lo;
    dpCtrlPkg::wordT pc;
    dpCtrlPkg::wordT mdr;

    assign memWrite     = ctrl.write;
    assign memWriteData = mdr;

    regFile #(.numRegs(numRegs)) regFile_i (
        .clk(clk), .rstN(rstN), .rIn(ctrl.rIn), .rOut(ctrl.rOut), .baOut(ctrl.baOut),
        .sel(sel), .busData(busData), .regData(regData)
    );

    irDecode irDecode_i (
        .clk(clk), .rstN(rstN), .irIn(ctrl.irIn),
        .gra(ctrl.gra), .grb(ctrl.grb), .grc(ctrl.grc),
        .busData(busData), .sel(sel), .opcode(opcode), .cExt(cExt)
    );

    aluUnit aluUnit_i (
        .clk(clk), .rstN(rstN), .yIn(ctrl.yIn), .zIn(ctrl.zIn),
        .hiIn(ctrl.hiIn), .loIn(ctrl.loIn), .opcode(opcode), .busData(busData),
        .zHigh(zHigh), .zLow(zLow), .hi(hi), .lo(lo)
    );

    memRegs memRegs_i (
        .clk(clk), .rstN(rstN), .pcIn(ctrl.pcIn), .marIn(ctrl.marIn), .mdrIn(ctrl.mdrIn),
        .read(ctrl.read), .outPortIn(ctrl.outPortIn), .busData(busData),
        .memDataIn(memDataIn), .pc(pc), .mdr(mdr), .memAddr(memAddr),
        .outPortData(outPortData)
    );

    busSelect busSelect_i (
        .ctrl(ctrl), .regData(regData), .pc(pc), .zHigh(zHigh), .zLow(zLow),
        .hi(hi), .lo(lo), .mdr(mdr), .inPortData(inPortData), .cExt(cExt),
        .busData(busData)
    );

endmodule

// File: verif/dataPathChecker.sv
`timescale 1ns/1ps

module dataPathChecker (
    input  logic                clk,
    input  logic                rstN,
    input  dpCtrlPkg::ctrlWordT ctrl,
    input  dpCtrlPkg::wordT     memDataIn,
    input  dpCtrlPkg::wordT     inPortData,
    input  dpCtrlPkg::wordT     busData,
    input  dpCtrlPkg::wordT     memAddr,
    input  dpCtrlPkg::wordT     memWriteData,
    input  logic                memWrite,
    input  dpCtrlPkg::wordT     outPortData,
    output int                  errCount,
    output int                  checkCount
);

    logic [31:0] regs [16];
    logic [31:0] ir, y, hiM, loM, pcM, marM, mdrM, outM;
    logic [63:0] zM;

    function automatic logic [3:0] selIdx(dpCtrlPkg::ctrlWordT w, logic [31:0] instr);
        if (w.gra) return instr[26:23];
        if (w.grb) return instr[22:19];
        if (w.grc) return instr[18:15];
        return 4'd0;
    endfunction

    function automatic logic [31:0] expBus(dpCtrlPkg::ctrlWordT w);
        logic [3:0] idx;
        idx = selIdx(w, ir);
        if (w.baOut) return (idx == 4'd0) ? 32'd0 : regs[idx];
        if (w.rOut) return regs[idx];
        case (w.busSrc)
            dpCtrlPkg::gpr:    return regs[idx];
            dpCtrlPkg::pc:     return pcM;
            dpCtrlPkg::zHigh:  return zM[63:32];
            dpCtrlPkg::zLow:   return zM[31:0];
            dpCtrlPkg::hi:     return hiM;
            dpCtrlPkg::lo:     return loM;
            dpCtrlPkg::mdr:    return mdrM;
            dpCtrlPkg::inPort: return inPortData;
            dpCtrlPkg::cExt:   return {{13{ir[18]}}, ir[18:0]};
            default:           return 32'd0;
        endcase
    endfunction

    // First operand is Y, second is the bus
    function automatic logic [63:0] aluModel(logic [4:0] op, logic [31:0] a, logic [31:0] b);
        logic [31:0]        r;
        logic signed [63:0] pa;
        logic signed [63:0] pb;
        pa = {{32{a[31]}}, a};
        pb = {{32{b[31]}}, b};
        case (op)
            5'd3:    r = a + b;
            5'd4:    r = a - b;
            5'd5:    r = a & b;
            5'd6:    r = a | b;
            5'd7:    r = a >> b[4:0];
            5'd9:    r = a << b[4:0];
            5'd15:   return pa * pb;
            5'd17:   r = -b;
            5'd18:   r = ~b;
            default: r = b;
        endcase
        return {{32{r[31]}}, r};
    endfunction

    task automatic compare(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            errCount++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    initial begin
        errCount   = 0;
        checkCount = 0;
    end

    always @(posedge clk or negedge rstN) begin
        logic [31:0] bus;
        logic [3:0]  idx;
        if (!rstN) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] = '0;
            end
            ir   = '0;
            y    = '0;
            zM   = '0;
            hiM  = '0;
            loM  = '0;
            pcM  = '0;
            marM = '0;
            mdrM = '0;
            outM = '0;
        end else begin
            bus = expBus(ctrl);
            idx = selIdx(ctrl, ir);
            compare("busData", busData, bus);
            compare("memAddr", memAddr, marM);
            compare("memWriteData", memWriteData, mdrM);
            compare("memWrite", {31'd0, memWrite}, {31'd0, ctrl.write});
            compare("outPortData", outPortData, outM);
            checkCount++;

            // Model update for this edge, Z before Y
            if (ctrl.zIn) zM = aluModel(ir[31:27], y, bus);
            if (ctrl.rIn) regs[idx] = bus;
            if (ctrl.irIn) ir = bus;
            if (ctrl.yIn) y = bus;
            if (ctrl.hiIn) hiM = bus;
            if (ctrl.loIn) loM = bus;
            if (ctrl.pcIn) pcM = bus;
            if (ctrl.marIn) marM = bus;
            if (ctrl.mdrIn) mdrM = ctrl.read ? memDataIn : bus;
            if (ctrl.outPortIn) outM = bus;
        end
    end

endmodule

// File: verif/dataPathTb.sv
`timescale 1ns/1ps

module dataPathTb;

    logic                clk;
    logic                rstN;
    dpCtrlPkg::ctrlWordT ctrl;
    dpCtrlPkg::wordT     memDataIn;
    dpCtrlPkg::wordT     inPortData;
    dpCtrlPkg::wordT     busData;
    dpCtrlPkg::wordT     memAddr;
    dpCtrlPkg::wordT     memWriteData;
    logic                memWrite;
    dpCtrlPkg::wordT     outPortData;
    int                  errCount;
    int                  checkCount;
    int                  otherErrors;
    logic [31:0]         seed;
    logic [4:0]          opList [9] = '{5'd3, 5'd4, 5'd5, 5'd6, 5'd7, 5'd9, 5'd15, 5'd17, 5'd18};

    dataPath #(.numRegs(16)) dut_i (
        .clk(clk), .rstN(rstN), .ctrl(ctrl), .memDataIn(memDataIn),
        .inPortData(inPortData), .busData(busData), .memAddr(memAddr),
        .memWriteData(memWriteData), .memWrite(memWrite), .outPortData(outPortData)
    );

    dataPathChecker checker_i (
        .clk(clk), .rstN(rstN), .ctrl(ctrl), .memDataIn(memDataIn),
        .inPortData(inPortData), .busData(busData), .memAddr(memAddr),
        .memWriteData(memWriteData), .memWrite(memWrite), .outPortData(outPortData),
        .errCount(errCount), .checkCount(checkCount)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] nextRand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic dpCtrlPkg::ctrlWordT idleWord();
        dpCtrlPkg::ctrlWordT w;
        w        = '0;
        w.busSrc = dpCtrlPkg::none;
        return w;
    endfunction

    // One control word for one clock, inputs change on the falling edge
    task automatic step(dpCtrlPkg::ctrlWordT w);
        @(negedge clk);
        ctrl       = w;
        inPortData = nextRand();
        memDataIn  = nextRand();
    endtask

    task automatic busStep(dpCtrlPkg::busSrcE src, logic [2:0] gr, logic [3:0] strobes);
        dpCtrlPkg::ctrlWordT w;
        w        = idleWord();
        w.busSrc = src;
        {w.gra, w.grb, w.grc} = gr;
        {w.rIn, w.rOut, w.baOut, w.write} = strobes;
        step(w);
    endtask

    task automatic loadIr(logic [31:0] instr);
        dpCtrlPkg::ctrlWordT w;
        w        = idleWord();
        w.busSrc = dpCtrlPkg::inPort;
        w.irIn   = 1'b1;
        @(negedge clk);
        ctrl       = w;
        inPortData = instr;
    endtask

    // Memory word through MDR into the register picked by gra
    task automatic memToReg();
        dpCtrlPkg::ctrlWordT w;
        w       = idleWord();
        w.read  = 1'b1;
        w.mdrIn = 1'b1;
        step(w);
        w        = idleWord();
        w.busSrc = dpCtrlPkg::mdr;
        w.gra    = 1'b1;
        w.rIn    = 1'b1;
        step(w);
        busStep(dpCtrlPkg::none, 3'b100, 4'b0100);
    endtask

    task automatic aluSequence();
        dpCtrlPkg::ctrlWordT w;
        logic [31:0] instr;
        instr = nextRand();
        instr[31:27] = (instr[0]) ? opList[nextRand() % 9] : instr[31:27];
        loadIr(instr);
        w = idleWord();
        w.busSrc = dpCtrlPkg::inPort;
        w.gra = 1'b1;
        w.rIn = 1'b1;
        step(w);
        w.gra = 1'b0;
        w.grb = 1'b1;
        step(w);
        w = idleWord();
        w.busSrc = dpCtrlPkg::none;
        w.gra = 1'b1;
        w.rOut = 1'b1;
        w.yIn = 1'b1;
        step(w);
        w.gra = 1'b0;
        w.grb = 1'b1;
        w.yIn = 1'b0;
        w.zIn = 1'b1;
        step(w);
        w = idleWord();
        w.busSrc = dpCtrlPkg::zLow;
        w.loIn = 1'b1;
        step(w);
        w.busSrc = dpCtrlPkg::zHigh;
        w.loIn = 1'b0;
        w.hiIn = 1'b1;
        step(w);
        busStep(dpCtrlPkg::lo, 3'b000, 4'b0000);
        busStep(dpCtrlPkg::hi, 3'b000, 4'b0000);
    endtask

    task automatic pcSequence();
        dpCtrlPkg::ctrlWordT w;
        logic [31:0]         rnd;
        w = idleWord();
        w.busSrc = dpCtrlPkg::inPort;
        w.pcIn = 1'b1;
        step(w);
        w = idleWord();
        w.busSrc = dpCtrlPkg::pc;
        w.marIn = 1'b1;
        w.yIn = 1'b1;
        step(w);
        // Add with a random constant
        rnd = nextRand();
        loadIr({5'd3, rnd[26:0]});
        w = idleWord();
        w.busSrc = dpCtrlPkg::cExt;
        w.zIn = 1'b1;
        step(w);
        w = idleWord();
        w.busSrc = dpCtrlPkg::zLow;
        w.pcIn = 1'b1;
        step(w);
        w = idleWord();
        w.busSrc = dpCtrlPkg::pc;
        w.marIn = 1'b1;
        step(w);
    endtask

    task automatic portSequence();
        dpCtrlPkg::ctrlWordT w;
        logic [31:0]         rnd;
        w = idleWord();
        w.busSrc = dpCtrlPkg::inPort;
        w.outPortIn = 1'b1;
        rnd = nextRand();
        w.mdrIn = rnd[0];
        step(w);
        rnd = nextRand();
        busStep(dpCtrlPkg::mdr, 3'b000, {3'b000, rnd[0]});
    endtask

    initial begin
        int snapshot;
        int waited;
        seed        = 32'd30473;
        otherErrors = 0;
        clk         = 1'b0;
        rstN        = 1'b0;
        ctrl        = idleWord();
        memDataIn   = '0;
        inPortData  = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        ////////////////////
        // Reset values
        ////////////////////
        for (int s = 0; s <= 9; s++) begin
            busStep(dpCtrlPkg::busSrcE'(s), 3'b000, 4'b0000);
        end
        busStep(dpCtrlPkg::none, 3'b001, 4'b0100);

        for (int n = 0; n < 40; n++) begin
            loadIr(nextRand());
            memToReg();
            aluSequence();
            loadIr(nextRand());
            busStep(dpCtrlPkg::cExt, 3'b000, 4'b0000);
            loadIr(nextRand() & 32'hf87f_ffff);
            busStep(dpCtrlPkg::none, 3'b100, 4'b0010);
            pcSequence();
            portSequence();
        end
        step(idleWord());

        // Let the checker see the last word
        snapshot = checkCount;
        waited   = 0;
        while (checkCount <= snapshot && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        if (checkCount <= snapshot) begin
            otherErrors++;
            $display("Checker stopped comparing before the end of the test");
        end

        $display("Checks: %0d, mismatches: %0d, other errors: %0d",
                 checkCount, errCount, otherErrors);
        if (errCount == 0 && otherErrors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: dataPath.f
rtl/dpCtrlPkg.sv
rtl/isaPkg.sv
rtl/regFile.sv
rtl/irDecode.sv
rtl/aluUnit.sv
rtl/memRegs.sv
rtl/busSelect.sv
rtl/dataPath.sv
verif/dataPathChecker.sv
verif/dataPathTb.sv

// File: run.sh
#!/bin/bash
# Build and run the datapath testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f dataPath.f --top-module dataPathTb -o simv \
    > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/simv > sim.log 2>&1 || echo "Simulator returned an error status"

grep -q "^Finished with errors" sim.log && { echo "FAIL"; exit 1; }
grep -q "^Finished with no errors" sim.log && echo "PASS" || { echo "No result in sim.log"; exit 1; }
